//--- router_arb_pkg.sv
`default_nettype none

package router_arb_pkg;

	localparam int NUM_PORTS = 5; // N, S, W, E, L.
	localparam int NUM_CAND = 4;  // A port never requests itself.
	localparam int ADDR_W = 8;
	localparam int COORD_W = 4;   // High nibble is x, low nibble is y.

	typedef logic [2:0] port_t;

	localparam port_t PORT_N = 3'd0;
	localparam port_t PORT_S = 3'd1;
	localparam port_t PORT_W = 3'd2;
	localparam port_t PORT_E = 3'd3;
	localparam port_t PORT_L = 3'd4;
	localparam port_t PORT_NONE = 3'd7; // No request pending.

	// One-hot or zero, indexed by input port code.
	typedef logic [NUM_PORTS-1:0] grant_t;

	// One-hot, bit k gives candidate k top priority.
	typedef logic [NUM_CAND-1:0] order_t;

	localparam order_t ORDER_RESET = order_t'(1);

endpackage

`default_nettype wire

//--- yx_route.sv
`timescale 1ns/1ps
`default_nettype none

module yx_route (
	input  wire logic [router_arb_pkg::ADDR_W-1:0] addr_header_i,
	input  wire logic [router_arb_pkg::ADDR_W-1:0] addr_router_i,
	output router_arb_pkg::port_t                  port_o
);

	import router_arb_pkg::*;

	logic [COORD_W-1:0] dst_x;
	logic [COORD_W-1:0] dst_y;
	logic [COORD_W-1:0] cur_x;
	logic [COORD_W-1:0] cur_y;

	assign dst_x = addr_header_i[ADDR_W-1:COORD_W];
	assign dst_y = addr_header_i[COORD_W-1:0];
	assign cur_x = addr_router_i[ADDR_W-1:COORD_W];
	assign cur_y = addr_router_i[COORD_W-1:0];

	// Resolve y first, then x.
	always_comb begin
		if (dst_y > cur_y) begin
			port_o = PORT_N;
		end else if (dst_y < cur_y) begin
			port_o = PORT_S;
		end else if (dst_x > cur_x) begin
			port_o = PORT_E;
		end else if (dst_x < cur_x) begin
			port_o = PORT_W;
		end else begin
			port_o = PORT_L; // Arrived.
		end
	end

endmodule

`default_nettype wire

//--- nexthop_reg.sv
`timescale 1ns/1ps
`default_nettype none

module nexthop_reg (
	input  wire logic            clk,
	input  wire logic            reset_i,
	input  wire logic            write_i,
	input  router_arb_pkg::port_t port_i,
	output router_arb_pkg::port_t port_o
);

	import router_arb_pkg::*;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			port_o <= PORT_NONE;
		end else if (write_i) begin
			port_o <= port_i;
		end
	end

	// Codes 5 and 6 are never produced by the router.
	a_valid_code: assert property (@(posedge clk) disable iff (reset_i)
		write_i |=> (port_o <= PORT_L) || (port_o == PORT_NONE))
		else $error("nexthop_reg: illegal port code %0d stored", port_o);

endmodule

`default_nettype wire

//--- rr_order_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module rr_order_ctrl (
	input  wire logic                                clk,
	input  wire logic                                reset_i,
	input  wire logic [router_arb_pkg::NUM_PORTS-1:0] change_order_i,
	output router_arb_pkg::order_t                   order_n_o,
	output router_arb_pkg::order_t                   order_s_o,
	output router_arb_pkg::order_t                   order_w_o,
	output router_arb_pkg::order_t                   order_e_o,
	output router_arb_pkg::order_t                   order_l_o
);

	import router_arb_pkg::*;

	order_t order_q [NUM_PORTS]; // Indexed by output port code.

	for (genvar g = 0; g < NUM_PORTS; g++) begin : g_order
		always_ff @(posedge clk) begin
			if (reset_i) begin
				order_q[g] <= ORDER_RESET;
			end else if (change_order_i[g]) begin
				// Move priority one candidate up, wrapping at the top.
				order_q[g] <= {order_q[g][NUM_CAND-2:0], order_q[g][NUM_CAND-1]};
			end
		end

		a_onehot: assert property (@(posedge clk) disable iff (reset_i)
			$onehot(order_q[g]))
			else $error("rr_order_ctrl: order %0d lost its one-hot form", g);
	end

	assign order_n_o = order_q[PORT_N];
	assign order_s_o = order_q[PORT_S];
	assign order_w_o = order_q[PORT_W];
	assign order_e_o = order_q[PORT_E];
	assign order_l_o = order_q[PORT_L];

endmodule

`default_nettype wire

//--- rr_select.sv
`timescale 1ns/1ps
`default_nettype none

module rr_select #(
	parameter router_arb_pkg::port_t OUT_PORT = router_arb_pkg::PORT_N
) (
	input  router_arb_pkg::port_t  nexthop_n_i,
	input  router_arb_pkg::port_t  nexthop_s_i,
	input  router_arb_pkg::port_t  nexthop_w_i,
	input  router_arb_pkg::port_t  nexthop_e_i,
	input  router_arb_pkg::port_t  nexthop_l_i,
	input  router_arb_pkg::order_t order_i,
	output router_arb_pkg::grant_t grant_o,
	output logic                   to_cs_o
);

	import router_arb_pkg::*;

	localparam int IDX_W = $clog2(NUM_CAND);

	port_t                  nexthop [NUM_PORTS];
	logic [NUM_CAND-1:0]    req;
	logic [NUM_CAND-1:0]    at_or_above;
	logic [2*NUM_CAND-1:0]  scan;
	logic                   win_valid;
	logic [IDX_W-1:0]       win_idx;

	// Candidate k is the k-th port code other than OUT_PORT.
	function automatic port_t cand_code(input int k);
		return (k < int'(OUT_PORT)) ? port_t'(k) : port_t'(k + 1);
	endfunction

	assign nexthop[PORT_N] = nexthop_n_i;
	assign nexthop[PORT_S] = nexthop_s_i;
	assign nexthop[PORT_W] = nexthop_w_i;
	assign nexthop[PORT_E] = nexthop_e_i;
	assign nexthop[PORT_L] = nexthop_l_i;

	for (genvar k = 0; k < NUM_CAND; k++) begin : g_req
		assign req[k] = (nexthop[cand_code(k)] == OUT_PORT);
	end

	// Upper copy of req covers the wrap past the last candidate.
	assign at_or_above = ~(order_i - order_t'(1));
	assign scan = {req, req & at_or_above};

	always_comb begin
		win_valid = 1'b0;
		win_idx = '0;
		for (int i = 0; i < 2 * NUM_CAND; i++) begin
			if (!win_valid && scan[i]) begin
				win_valid = 1'b1;
				win_idx = IDX_W'(i % NUM_CAND);
			end
		end
	end

	always_comb begin
		grant_o = '0;
		for (int k = 0; k < NUM_CAND; k++) begin
			if (win_valid && win_idx == IDX_W'(k)) begin
				grant_o[cand_code(k)] = 1'b1;
			end
		end
	end

	assign to_cs_o = |grant_o;

	always_comb begin
		a_grant_onehot: assert #0 ($onehot0(grant_o))
			else $error("rr_select %0d: grant not one-hot", OUT_PORT);
		a_no_self: assert #0 (!grant_o[OUT_PORT])
			else $error("rr_select %0d: port granted to itself", OUT_PORT);
		// Any request for this output must win a grant.
		a_to_cs: assert #0 (to_cs_o == |req)
			else $error("rr_select %0d: to_cs disagrees with requests", OUT_PORT);
	end

endmodule

`default_nettype wire

//--- arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module arbiter (
	input  wire logic                                clk,
	input  wire logic                                reset_i,
	input  wire logic [router_arb_pkg::ADDR_W-1:0]    addr_router_i,
	input  wire logic [router_arb_pkg::ADDR_W-1:0]    header_n_i,
	input  wire logic [router_arb_pkg::ADDR_W-1:0]    header_s_i,
	input  wire logic [router_arb_pkg::ADDR_W-1:0]    header_w_i,
	input  wire logic [router_arb_pkg::ADDR_W-1:0]    header_e_i,
	input  wire logic [router_arb_pkg::ADDR_W-1:0]    header_l_i,
	input  wire logic                                nhr_write_n_i,
	input  wire logic                                nhr_write_s_i,
	input  wire logic                                nhr_write_w_i,
	input  wire logic                                nhr_write_e_i,
	input  wire logic                                nhr_write_l_i,
	input  wire logic [router_arb_pkg::NUM_PORTS-1:0] change_order_i,
	output router_arb_pkg::grant_t                   grant_n_o,
	output router_arb_pkg::grant_t                   grant_s_o,
	output router_arb_pkg::grant_t                   grant_w_o,
	output router_arb_pkg::grant_t                   grant_e_o,
	output router_arb_pkg::grant_t                   grant_l_o,
	output logic [router_arb_pkg::NUM_PORTS-1:0]      to_cs_o
);

	import router_arb_pkg::*;

	port_t route_n, route_s, route_w, route_e, route_l; // Combinational routes.
	port_t nh_n, nh_s, nh_w, nh_e, nh_l;                // Registered next-hops.
	order_t ord_n, ord_s, ord_w, ord_e, ord_l;

	yx_route u_route_n (.addr_header_i(header_n_i), .addr_router_i(addr_router_i), .port_o(route_n));
	yx_route u_route_s (.addr_header_i(header_s_i), .addr_router_i(addr_router_i), .port_o(route_s));
	yx_route u_route_w (.addr_header_i(header_w_i), .addr_router_i(addr_router_i), .port_o(route_w));
	yx_route u_route_e (.addr_header_i(header_e_i), .addr_router_i(addr_router_i), .port_o(route_e));
	yx_route u_route_l (.addr_header_i(header_l_i), .addr_router_i(addr_router_i), .port_o(route_l));

	nexthop_reg u_nh_n (.clk, .reset_i, .write_i(nhr_write_n_i), .port_i(route_n), .port_o(nh_n));
	nexthop_reg u_nh_s (.clk, .reset_i, .write_i(nhr_write_s_i), .port_i(route_s), .port_o(nh_s));
	nexthop_reg u_nh_w (.clk, .reset_i, .write_i(nhr_write_w_i), .port_i(route_w), .port_o(nh_w));
	nexthop_reg u_nh_e (.clk, .reset_i, .write_i(nhr_write_e_i), .port_i(route_e), .port_o(nh_e));
	nexthop_reg u_nh_l (.clk, .reset_i, .write_i(nhr_write_l_i), .port_i(route_l), .port_o(nh_l));

	rr_order_ctrl u_order (
		.clk,
		.reset_i,
		.change_order_i,
		.order_n_o(ord_n),
		.order_s_o(ord_s),
		.order_w_o(ord_w),
		.order_e_o(ord_e),
		.order_l_o(ord_l)
	);

	// Every selector sees all next-hops and picks those aimed at its own port.
	rr_select #(.OUT_PORT(PORT_N)) u_sel_n (
		.nexthop_n_i(nh_n), .nexthop_s_i(nh_s), .nexthop_w_i(nh_w),
		.nexthop_e_i(nh_e), .nexthop_l_i(nh_l), .order_i(ord_n),
		.grant_o(grant_n_o), .to_cs_o(to_cs_o[PORT_N])
	);

	rr_select #(.OUT_PORT(PORT_S)) u_sel_s (
		.nexthop_n_i(nh_n), .nexthop_s_i(nh_s), .nexthop_w_i(nh_w),
		.nexthop_e_i(nh_e), .nexthop_l_i(nh_l), .order_i(ord_s),
		.grant_o(grant_s_o), .to_cs_o(to_cs_o[PORT_S])
	);

	rr_select #(.OUT_PORT(PORT_W)) u_sel_w (
		.nexthop_n_i(nh_n), .nexthop_s_i(nh_s), .nexthop_w_i(nh_w),
		.nexthop_e_i(nh_e), .nexthop_l_i(nh_l), .order_i(ord_w),
		.grant_o(grant_w_o), .to_cs_o(to_cs_o[PORT_W])
	);

	rr_select #(.OUT_PORT(PORT_E)) u_sel_e (
		.nexthop_n_i(nh_n), .nexthop_s_i(nh_s), .nexthop_w_i(nh_w),
		.nexthop_e_i(nh_e), .nexthop_l_i(nh_l), .order_i(ord_e),
		.grant_o(grant_e_o), .to_cs_o(to_cs_o[PORT_E])
	);

	rr_select #(.OUT_PORT(PORT_L)) u_sel_l (
		.nexthop_n_i(nh_n), .nexthop_s_i(nh_s), .nexthop_w_i(nh_w),
		.nexthop_e_i(nh_e), .nexthop_l_i(nh_l), .order_i(ord_l),
		.grant_o(grant_l_o), .to_cs_o(to_cs_o[PORT_L])
	);

endmodule

`default_nettype wire

//--- arbiter_tb_ref.svh
`ifndef ARBITER_TB_REF_SVH
`define ARBITER_TB_REF_SVH

// Model state, indexed by port code.
port_t  m_nexthop [NUM_PORTS];
order_t m_order [NUM_PORTS];

// Dimension-ordered routing, y before x.
function automatic port_t ref_route(input logic [ADDR_W-1:0] header,
		input logic [ADDR_W-1:0] router);
	int dx;
	int dy;
	dx = int'(header[ADDR_W-1:COORD_W]) - int'(router[ADDR_W-1:COORD_W]);
	dy = int'(header[COORD_W-1:0]) - int'(router[COORD_W-1:0]);
	if (dy != 0)
		return (dy > 0) ? PORT_N : PORT_S;
	if (dx != 0)
		return (dx > 0) ? PORT_E : PORT_W;
	return PORT_L;
endfunction

function automatic int order_index(input order_t ord);
	int idx;
	idx = 0;
	for (int i = 0; i < NUM_CAND; i++) begin
		if (ord[i])
			idx = i;
	end
	return idx;
endfunction

// Scan candidates of output out from its order position, wrapping.
function automatic grant_t ref_grant(input int out);
	int     start;
	int     k;
	port_t  code;
	grant_t g;
	start = order_index(m_order[out]);
	g = '0;
	for (int step = 0; step < NUM_CAND; step++) begin
		k = (start + step) % NUM_CAND;
		code = (k < out) ? port_t'(k) : port_t'(k + 1); // Skip the output itself.
		if (g == '0 && m_nexthop[code] == port_t'(out))
			g[code] = 1'b1;
	end
	return g;
endfunction

function automatic void model_reset();
	for (int p = 0; p < NUM_PORTS; p++) begin
		m_nexthop[p] = PORT_NONE;
		m_order[p] = order_t'(1);
	end
endfunction

function automatic void model_step();
	int idx;
	for (int p = 0; p < NUM_PORTS; p++) begin
		if (wr[p])
			m_nexthop[p] = ref_route(hdr[p], addr_router);
		if (chg[p]) begin
			idx = (order_index(m_order[p]) + 1) % NUM_CAND;
			m_order[p] = order_t'(1) << idx;
		end
	end
endfunction

`endif

//--- arbiter_tb.sv
`timescale 1ns/1ps
`default_nettype none

module arbiter_tb;

	import router_arb_pkg::*;

	localparam int RESET_CYCLES = 16;
	localparam int RANDOM_CYCLES = 4000;
	localparam int TIMEOUT = 10000;
	localparam logic [ADDR_W-1:0] CENTER = 8'h77;
	localparam port_t RR_VISIT [NUM_CAND] = '{PORT_N, PORT_S, PORT_W, PORT_L};
	localparam grant_t HOLE_SEQ [3] = '{5'b00100, 5'b00100, 5'b00001};

	logic                 clk;
	logic                 reset_i;
	logic [ADDR_W-1:0]    addr_router;
	logic [ADDR_W-1:0]    hdr [NUM_PORTS];
	logic [NUM_PORTS-1:0] wr;
	logic [NUM_PORTS-1:0] chg;
	grant_t               dut_grant [NUM_PORTS];
	logic [NUM_PORTS-1:0] dut_to_cs;
	string                test_name;
	int                   check_count = 0;

	`include "arbiter_tb_ref.svh"

	arbiter uut (
		.clk(clk), .reset_i(reset_i), .addr_router_i(addr_router),
		.header_n_i(hdr[PORT_N]), .header_s_i(hdr[PORT_S]), .header_w_i(hdr[PORT_W]),
		.header_e_i(hdr[PORT_E]), .header_l_i(hdr[PORT_L]),
		.nhr_write_n_i(wr[PORT_N]), .nhr_write_s_i(wr[PORT_S]), .nhr_write_w_i(wr[PORT_W]),
		.nhr_write_e_i(wr[PORT_E]), .nhr_write_l_i(wr[PORT_L]),
		.change_order_i(chg),
		.grant_n_o(dut_grant[PORT_N]), .grant_s_o(dut_grant[PORT_S]),
		.grant_w_o(dut_grant[PORT_W]), .grant_e_o(dut_grant[PORT_E]),
		.grant_l_o(dut_grant[PORT_L]), .to_cs_o(dut_to_cs)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		reset_i = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		reset_i <= 1'b0;
	end

	always @(posedge clk) begin
		if (reset_i)
			model_reset();
		else
			model_step(); // Same strobes the DUT samples here.
	end

	task automatic check_grant(input string what, input grant_t exp, input grant_t act);
		if (exp !== act) begin
			$display("Mismatch %s %s: expected %b, actual %b", test_name, what, exp, act);
			$display("TEST FAILED");
			$fatal(1, "grant check failed");
		end
	endtask

	task automatic check_to_cs(input string what, input logic [NUM_PORTS-1:0] exp,
			input logic [NUM_PORTS-1:0] act);
		if (exp !== act) begin
			$display("Mismatch %s %s: expected %b, actual %b", test_name, what, exp, act);
			$display("TEST FAILED");
			$fatal(1, "to_cs check failed");
		end
	endtask

	task automatic fail_timeout(input string why);
		$display("Timeout: %s", why);
		$display("TEST FAILED");
		$fatal(1, "timeout");
	endtask

	// Outputs are settled half a cycle after the edge.
	always @(negedge clk) begin : compare
		grant_t               exp_g;
		logic [NUM_PORTS-1:0] exp_cs;
		if (!reset_i) begin
			for (int p = 0; p < NUM_PORTS; p++) begin
				exp_g = ref_grant(p);
				exp_cs[p] = |exp_g;
				check_grant($sformatf("model grant %0d", p), exp_g, dut_grant[p]);
			end
			check_to_cs("model to_cs", exp_cs, dut_to_cs);
			check_count++;
		end
	end

	task automatic wait_for_reset_release();
		int t;
		t = 0;
		while (reset_i !== 1'b0) begin
			@(posedge clk);
			t++;
			if (t > TIMEOUT)
				fail_timeout("reset was never released");
		end
	endtask

	task automatic wait_for_checks(input int target);
		int t;
		t = 0;
		while (check_count < target) begin
			@(posedge clk);
			t++;
			if (t > TIMEOUT)
				fail_timeout("comparison process stopped checking");
		end
	endtask

	// Writes one header into every input in mask, then waits past the load edge.
	task automatic write_headers(input logic [NUM_PORTS-1:0] mask,
			input logic [ADDR_W-1:0] header);
		@(posedge clk);
		for (int p = 0; p < NUM_PORTS; p++) begin
			if (mask[p])
				hdr[p] <= header;
		end
		wr <= mask;
		@(posedge clk);
		wr <= '0;
		@(negedge clk);
	endtask

	task automatic rotate(input int out);
		@(posedge clk);
		chg <= NUM_PORTS'(1) << out;
		@(posedge clk);
		chg <= '0;
		@(negedge clk);
	endtask

	initial begin
		int base;
		void'($urandom(32'h8e41));
		addr_router = CENTER;
		wr = '0;
		chg = '0;
		for (int p = 0; p < NUM_PORTS; p++)
			hdr[p] = '0;

		test_name = "reset";
		wait_for_reset_release();
		@(negedge clk);
		for (int p = 0; p < NUM_PORTS; p++)
			check_grant("idle grant", '0, dut_grant[p]);
		check_to_cs("idle to_cs", '0, dut_to_cs);

		test_name = "route";
		write_headers(5'b00001, CENTER); // North input, header is this router.
		check_grant("local", 5'b00001, dut_grant[PORT_L]);
		write_headers(5'b10000, 8'h7a);
		check_grant("north", 5'b10000, dut_grant[PORT_N]);
		write_headers(5'b10000, 8'h73);
		check_grant("south", 5'b10000, dut_grant[PORT_S]);
		write_headers(5'b10000, 8'h27);
		check_grant("west", 5'b10000, dut_grant[PORT_W]);
		write_headers(5'b10000, 8'hc7);
		check_grant("east", 5'b10000, dut_grant[PORT_E]);

		test_name = "round_robin";
		write_headers(5'b10111, 8'hb7); // All but east head east.
		check_grant("start", 5'b00001, dut_grant[PORT_E]);
		for (int i = 1; i <= 2 * NUM_CAND; i++) begin
			rotate(PORT_E);
			check_grant($sformatf("rotation %0d", i), grant_t'(1) << RR_VISIT[i % NUM_CAND],
				dut_grant[PORT_E]);
		end

		test_name = "holes";
		write_headers(5'b00010, 8'h79);
		write_headers(5'b10000, 8'h75);
		check_grant("order 0", 5'b00001, dut_grant[PORT_E]);
		check_to_cs("unrequested outputs", 5'b01011, dut_to_cs);
		for (int i = 0; i < 3; i++) begin
			rotate(PORT_E);
			check_grant($sformatf("order %0d", i + 1), HOLE_SEQ[i], dut_grant[PORT_E]);
		end

		test_name = "random";
		base = check_count;
		for (int i = 0; i < RANDOM_CYCLES; i++) begin
			@(posedge clk);
			addr_router <= ADDR_W'($urandom);
			for (int p = 0; p < NUM_PORTS; p++)
				hdr[p] <= ADDR_W'($urandom);
			wr <= NUM_PORTS'($urandom);
			chg <= NUM_PORTS'($urandom);
		end
		@(posedge clk);
		wr <= '0;
		chg <= '0;
		wait_for_checks(base + RANDOM_CYCLES);

		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+.
router_arb_pkg.sv
yx_route.sv
nexthop_reg.sv
rr_order_ctrl.sv
rr_select.sv
arbiter.sv
arbiter_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f filelist.f --top-module arbiter_tb -o arbiter_sim

./obj_dir/arbiter_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
	exit 1
fi
if ! grep -q "TEST OK" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
